/* list.f */
+incdir+common
common/rename_pkg.sv
common/uop_pkg.sv
common/commit_if.sv
rename/free_list.sv
rename/map_table.sv
rename/register_rename.sv
hw/rename_top.sv
verif/tb_rename.sv

/* run.sh */
#!/bin/sh
# Builds the rename testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rename -f list.f
out=$(./obj_dir/Vtb_rename)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi

/* verif/tb_rename.sv */
`include "rename_config.svh"

module tb_rename import rename_pkg::*, uop_pkg::*; ();

    localparam int FL_DEPTH   = `NUM_PREG - `NUM_AREG;
    localparam int FL_IDX_W   = $clog2(FL_DEPTH);
    localparam int RUN_CYCLES = 4 * 9 + 8 + 8 + 2 + 22 + 30; // resets plus bundles and commits.
    localparam int MARGIN     = 100;

    logic  clk, reset, recover;
    logic  in0_valid, in0_wen, in1_valid, in1_wen;
    tag_t  in0_tag, in1_tag, out0_tag, out1_tag;
    areg_t in0_rs1, in0_rs2, in0_rd, in1_rs1, in1_rs2, in1_rd;
    logic  out0_valid, out1_valid, allocatable;
    preg_t out0_prs1, out0_prs2, out0_prd, out0_prd_stale;
    preg_t out1_prs1, out1_prs2, out1_prd, out1_prd_stale;
    logic  cm0_valid, cm0_wen, cm1_valid, cm1_wen;
    areg_t cm0_ard, cm1_ard;
    preg_t cm0_prd_new, cm0_prd_stale, cm1_prd_new, cm1_prd_stale;

    // reference model.
    preg_t  spec_map [`NUM_AREG];
    preg_t  cm_map [`NUM_AREG];
    preg_t  fq [FL_DEPTH];
    int     head, cm_head, tail;
    areg_t  hist_ard [$];
    preg_t  hist_new [$];
    preg_t  hist_stale [$]; // renamed writes not yet committed.
    logic   rec_now;
    int     errors, checks;
    integer seed = 32'h1f45_8a3c;

    rename_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic areg_t rand_reg();
        return areg_t'($random(seed));
    endfunction

    task automatic check_preg(input string name, input preg_t got, input preg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic clear_inputs();
        {in0_valid, in0_wen, in0_tag, in0_rs1, in0_rs2, in0_rd} = '0;
        {in1_valid, in1_wen, in1_tag, in1_rs1, in1_rs2, in1_rd} = '0;
        {cm0_valid, cm0_wen, cm0_ard, cm0_prd_new, cm0_prd_stale} = '0;
        {cm1_valid, cm1_wen, cm1_ard, cm1_prd_new, cm1_prd_stale} = '0;
        recover = 1'b0;
    endtask

    task automatic do_reset();
        @(negedge clk);
        clear_inputs();
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < `NUM_AREG; i++) begin
            spec_map[areg_t'(i)] = preg_t'(i);
            cm_map[areg_t'(i)]   = preg_t'(i);
        end
        for (int i = 0; i < FL_DEPTH; i++) begin
            fq[FL_IDX_W'(i)] = preg_t'(`NUM_AREG + i);
        end
        head    = 0;
        cm_head = 0;
        tail    = FL_DEPTH;
        hist_ard.delete();
        hist_new.delete();
        hist_stale.delete();
    endtask

    task automatic rename_bundle(input logic v0, input areg_t s01, input areg_t s02,
                                 input areg_t d0, input logic w0, input logic v1,
                                 input areg_t s11, input areg_t s12, input areg_t d1,
                                 input logic w1);
        logic  alloc, g0, g1, b;
        preg_t p0, p1, e0s1, e0s2, e0d, e1s1, e1s2, e1d;
        tag_t  t0, t1;
        t0 = tag_t'($random(seed));
        t1 = tag_t'($random(seed));
        @(negedge clk);
        {in0_valid, in0_tag, in0_rs1, in0_rs2, in0_rd, in0_wen} = {v0, t0, s01, s02, d0, w0};
        {in1_valid, in1_tag, in1_rs1, in1_rs2, in1_rd, in1_wen} = {v1, t1, s11, s12, d1, w1};
        recover = rec_now;
        #10;
        alloc = (tail - head) >= 2;
        g0    = v0 && alloc;
        g1    = v1 && alloc;
        b     = g0 && w0; // slot 0 allocates this cycle.
        p0    = fq[FL_IDX_W'(head)];
        p1    = fq[FL_IDX_W'(head + (b ? 1 : 0))];
        e0s1  = spec_map[s01];
        e0s2  = spec_map[s02];
        e0d   = spec_map[d0];
        e1s1  = (b && s11 == d0) ? p0 : spec_map[s11];
        e1s2  = (b && s12 == d0) ? p0 : spec_map[s12];
        e1d   = (b && d1 == d0) ? p0 : spec_map[d1];
        check_bit("allocatable", allocatable, alloc);
        check_bit("out0_valid", out0_valid, g0);
        check_bit("out1_valid", out1_valid, g1);
        if (g0) begin
            check_tag("out0_tag", out0_tag, t0);
            check_preg("out0_prs1", out0_prs1, e0s1);
            check_preg("out0_prs2", out0_prs2, e0s2);
            check_preg("out0_prd_stale", out0_prd_stale, e0d);
            if (w0) check_preg("out0_prd", out0_prd, p0);
        end
        if (g1) begin
            check_tag("out1_tag", out1_tag, t1);
            check_preg("out1_prs1", out1_prs1, e1s1);
            check_preg("out1_prs2", out1_prs2, e1s2);
            check_preg("out1_prd_stale", out1_prd_stale, e1d);
            if (w1) check_preg("out1_prd", out1_prd, p1);
        end
        @(posedge clk);
        if (rec_now) begin
            spec_map = cm_map; // recover wins over the renames.
            head     = cm_head;
            hist_ard.delete();
            hist_new.delete();
            hist_stale.delete();
        end else begin
            if (b) begin
                hist_ard.push_back(d0);
                hist_new.push_back(p0);
                hist_stale.push_back(e0d);
                spec_map[d0] = p0;
                head++;
            end
            if (g1 && w1) begin
                hist_ard.push_back(d1);
                hist_new.push_back(p1);
                hist_stale.push_back(e1d);
                spec_map[d1] = p1;
                head++;
            end
        end
    endtask

    // retires the two oldest renamed writes.
    task automatic commit_pair();
        areg_t a0, a1;
        preg_t n0, n1, s0, s1;
        a0 = hist_ard.pop_front();
        n0 = hist_new.pop_front();
        s0 = hist_stale.pop_front();
        a1 = hist_ard.pop_front();
        n1 = hist_new.pop_front();
        s1 = hist_stale.pop_front();
        @(negedge clk);
        {in0_valid, in1_valid} = 2'b00;
        {cm0_valid, cm0_wen, cm0_ard, cm0_prd_new, cm0_prd_stale} = {2'b11, a0, n0, s0};
        {cm1_valid, cm1_wen, cm1_ard, cm1_prd_new, cm1_prd_stale} = {2'b11, a1, n1, s1};
        @(posedge clk);
        cm_map[a0] = n0;
        cm_map[a1] = n1;
        fq[FL_IDX_W'(tail)]     = s0;
        fq[FL_IDX_W'(tail + 1)] = s1;
        tail    += 2;
        cm_head += 2;
        @(negedge clk);
        {cm0_valid, cm1_valid} = 2'b00;
    endtask

    task automatic test_identity();
        do_reset();
        repeat (8) begin
            rename_bundle(1'b1, rand_reg(), rand_reg(), rand_reg(), 1'b0,
                          1'b1, rand_reg(), rand_reg(), rand_reg(), 1'b0);
        end
    endtask

    task automatic test_alloc_order();
        do_reset();
        for (int i = 0; i < 8; i++) begin
            rename_bundle(1'b1, rand_reg(), rand_reg(), rand_reg(), i % 3 != 1,
                          1'b1, rand_reg(), rand_reg(), rand_reg(), i[0]);
        end
    endtask

    task automatic test_bypass();
        areg_t r;
        r = rand_reg();
        rename_bundle(1'b1, rand_reg(), rand_reg(), r, 1'b1, 1'b1, r, r, r, 1'b1);
        rename_bundle(1'b1, r, r, rand_reg(), 1'b0, 1'b0, r, r, r, 1'b0);
    endtask

    task automatic test_exhaustion();
        areg_t r;
        do_reset();
        repeat (15) begin
            rename_bundle(1'b1, rand_reg(), rand_reg(), rand_reg(), 1'b1,
                          1'b1, rand_reg(), rand_reg(), rand_reg(), 1'b1);
        end
        rename_bundle(1'b1, rand_reg(), rand_reg(), rand_reg(), 1'b1,
                      1'b0, rand_reg(), rand_reg(), rand_reg(), 1'b0); // one entry left.
        r = rand_reg();
        repeat (2) begin
            rename_bundle(1'b1, rand_reg(), rand_reg(), r, 1'b1,
                          1'b1, rand_reg(), rand_reg(), r, 1'b1);
        end
        commit_pair();
        rename_bundle(1'b1, r, r, r, 1'b1, 1'b0, r, r, r, 1'b0); // stalled writes left no trace.
    endtask

    task automatic test_commit_recover();
        do_reset();
        for (int k = 0; k < 4; k++) begin
            rename_bundle(1'b1, rand_reg(), rand_reg(), areg_t'(2 * k + 1), 1'b1,
                          1'b1, rand_reg(), rand_reg(), areg_t'(2 * k + 2), 1'b1);
        end
        commit_pair();
        commit_pair();
        rename_bundle(1'b1, rand_reg(), rand_reg(), 5'd1, 1'b1, 1'b1, 5'd2, 5'd3, 5'd5, 1'b1);
        rec_now = 1'b1;
        rename_bundle(1'b1, rand_reg(), rand_reg(), 5'd3, 1'b1, 1'b1, 5'd4, 5'd6, 5'd4, 1'b1);
        rec_now = 1'b0;
        for (int k = 0; k < 4; k++) begin
            rename_bundle(1'b1, areg_t'(2 * k + 1), areg_t'(2 * k + 2), 5'd0, 1'b0,
                          1'b1, areg_t'(2 * k + 2), areg_t'(2 * k + 1), 5'd9, 1'b0);
        end
        repeat (15) begin
            rename_bundle(1'b1, rand_reg(), rand_reg(), rand_reg(), 1'b1,
                          1'b1, rand_reg(), rand_reg(), rand_reg(), 1'b1);
        end
    endtask

    initial begin
        #((RUN_CYCLES + MARGIN) * 40);
        $display("timeout: the tests did not finish within %0d cycles", RUN_CYCLES + MARGIN);
        $display("test failed");
        $finish;
    end

    initial begin
        clear_inputs();
        reset   = 1'b1;
        rec_now = 1'b0;
        errors  = 0;
        checks  = 0;
        test_identity();
        test_alloc_order();
        test_bypass();
        test_exhaustion();
        test_commit_recover();
        $display("summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* hw/rename_top.sv */
module rename_top import rename_pkg::*; import uop_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  recover,
    input  logic  in0_valid,
    input  tag_t  in0_tag,
    input  areg_t in0_rs1,
    input  areg_t in0_rs2,
    input  areg_t in0_rd,
    input  logic  in0_wen,
    input  logic  in1_valid,
    input  tag_t  in1_tag,
    input  areg_t in1_rs1,
    input  areg_t in1_rs2,
    input  areg_t in1_rd,
    input  logic  in1_wen,
    output logic  out0_valid,
    output tag_t  out0_tag,
    output preg_t out0_prs1,
    output preg_t out0_prs2,
    output preg_t out0_prd,
    output preg_t out0_prd_stale,
    output logic  out1_valid,
    output tag_t  out1_tag,
    output preg_t out1_prs1,
    output preg_t out1_prs2,
    output preg_t out1_prd,
    output preg_t out1_prd_stale,
    input  logic  cm0_valid,
    input  logic  cm0_wen,
    input  areg_t cm0_ard,
    input  preg_t cm0_prd_new,
    input  preg_t cm0_prd_stale,
    input  logic  cm1_valid,
    input  logic  cm1_wen,
    input  areg_t cm1_ard,
    input  preg_t cm1_prd_new,
    input  preg_t cm1_prd_stale,
    output logic  allocatable
);

    uop_bundle_t in0;
    uop_bundle_t in1;
    uop_bundle_t out0;
    uop_bundle_t out1;

    commit_if i_commit_if ();

    // physical fields are filled in by rename.
    assign in0 = '{valid: in0_valid, tag: in0_tag, rs1: in0_rs1, rs2: in0_rs2, rd: in0_rd,
                   wen: in0_wen, default: '0};
    assign in1 = '{valid: in1_valid, tag: in1_tag, rs1: in1_rs1, rs2: in1_rs2, rd: in1_rd,
                   wen: in1_wen, default: '0};

    assign i_commit_if.valid0 = cm0_valid;
    assign i_commit_if.info0  = '{wen: cm0_wen, ard: cm0_ard, prd_new: cm0_prd_new,
                                  prd_stale: cm0_prd_stale};
    assign i_commit_if.valid1 = cm1_valid;
    assign i_commit_if.info1  = '{wen: cm1_wen, ard: cm1_ard, prd_new: cm1_prd_new,
                                  prd_stale: cm1_prd_stale};

    register_rename i_register_rename (
        .clk         (clk),
        .reset       (reset),
        .recover     (recover),
        .in0         (in0),
        .in1         (in1),
        .out0        (out0),
        .out1        (out1),
        .commit      (i_commit_if.sink),
        .allocatable (allocatable)
    );

    assign out0_valid     = out0.valid;
    assign out0_tag       = out0.tag;
    assign out0_prs1      = out0.prs1;
    assign out0_prs2      = out0.prs2;
    assign out0_prd       = out0.prd;
    assign out0_prd_stale = out0.prd_stale;

    assign out1_valid     = out1.valid;
    assign out1_tag       = out1.tag;
    assign out1_prs1      = out1.prs1;
    assign out1_prs2      = out1.prs2;
    assign out1_prd       = out1.prd;
    assign out1_prd_stale = out1.prd_stale;

endmodule

/* rename/register_rename.sv */
module register_rename import rename_pkg::*; import uop_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        recover,
    input  uop_bundle_t in0,
    input  uop_bundle_t in1,
    output uop_bundle_t out0,
    output uop_bundle_t out1,
    commit_if.sink      commit,
    output logic        allocatable
);

    logic         slot_valid0;
    logic         slot_valid1;
    preg_t        prd0;
    preg_t        prd1;
    rename_req_t  req0;
    rename_req_t  req1;
    rename_resp_t resp0;
    rename_resp_t resp1;

    assign slot_valid0 = in0.valid && allocatable;
    assign slot_valid1 = in1.valid && allocatable;

    assign req0 = '{rs1: in0.rs1, rs2: in0.rs2, rd: in0.rd, wen: in0.wen};
    assign req1 = '{rs1: in1.rs1, rs2: in1.rs2, rd: in1.rd, wen: in1.wen};

    free_list i_free_list (
        .clk         (clk),
        .reset       (reset),
        .recover     (recover),
        .pop0        (slot_valid0 && in0.wen),
        .pop1        (slot_valid1 && in1.wen),
        .prd0        (prd0),
        .prd1        (prd1),
        .commit      (commit),
        .allocatable (allocatable)
    );

    map_table i_map_table (
        .clk      (clk),
        .reset    (reset),
        .recover  (recover),
        .valid0   (slot_valid0),
        .valid1   (slot_valid1),
        .req0     (req0),
        .req1     (req1),
        .prd_new0 (prd0),
        .prd_new1 (prd1),
        .resp0    (resp0),
        .resp1    (resp1),
        .commit   (commit)
    );

    always_comb begin
        out0           = in0;
        out0.valid     = slot_valid0;
        out0.prs1      = resp0.prs1;
        out0.prs2      = resp0.prs2;
        out0.prd       = prd0;
        out0.prd_stale = resp0.prd_stale;
    end

    always_comb begin
        out1           = in1;
        out1.valid     = slot_valid1;
        out1.prs1      = resp1.prs1;
        out1.prs2      = resp1.prs2;
        out1.prd       = prd1;
        out1.prd_stale = resp1.prd_stale;
    end

endmodule

/* rename/map_table.sv */
`include "rename_config.svh"

module map_table import rename_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         recover,
    input  logic         valid0,
    input  logic         valid1,
    input  rename_req_t  req0,
    input  rename_req_t  req1,
    input  preg_t        prd_new0,
    input  preg_t        prd_new1,
    output rename_resp_t resp0,
    output rename_resp_t resp1,
    commit_if.sink       commit
);

    preg_t spec_map    [`NUM_AREG];
    preg_t cm_map      [`NUM_AREG];
    preg_t cm_map_next [`NUM_AREG];
    logic  write0;
    logic  write1;
    logic  cm_write0;
    logic  cm_write1;

    assign write0    = valid0 && req0.wen;
    assign write1    = valid1 && req1.wen;
    assign cm_write0 = commit.valid0 && commit.info0.wen;
    assign cm_write1 = commit.valid1 && commit.info1.wen;

    always_comb begin
        resp0.prs1      = spec_map[req0.rs1];
        resp0.prs2      = spec_map[req0.rs2];
        resp0.prd_stale = spec_map[req0.rd];
    end

    // slot 1 must see the destination slot 0 is allocating this cycle
    always_comb begin
        resp1.prs1      = spec_map[req1.rs1];
        resp1.prs2      = spec_map[req1.rs2];
        resp1.prd_stale = spec_map[req1.rd];
        if (write0 && req1.rs1 == req0.rd) begin
            resp1.prs1 = prd_new0;
        end
        if (write0 && req1.rs2 == req0.rd) begin
            resp1.prs2 = prd_new0;
        end
        if (write0 && req1.rd == req0.rd) begin
            resp1.prd_stale = prd_new0;
        end
    end

    always_comb begin
        cm_map_next = cm_map;
        if (cm_write0) begin
            cm_map_next[commit.info0.ard] = commit.info0.prd_new;
        end
        if (cm_write1) begin
            cm_map_next[commit.info1.ard] = commit.info1.prd_new; // younger commit wins.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_AREG; i++) begin
                cm_map[i] <= preg_t'(i); // identity map.
            end
        end else begin
            cm_map <= cm_map_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_AREG; i++) begin
                spec_map[i] <= preg_t'(i);
            end
        end else if (recover) begin
            spec_map <= cm_map_next; // includes this edge's commits.
        end else begin
            if (write0) begin
                spec_map[req0.rd] <= prd_new0;
            end
            if (write1) begin
                spec_map[req1.rd] <= prd_new1; // later write wins on equal rd.
            end
        end
    end

endmodule

/* rename/free_list.sv */
`include "rename_config.svh"

module free_list import rename_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   recover,
    input  logic   pop0,
    input  logic   pop1,
    output preg_t  prd0,
    output preg_t  prd1,
    commit_if.sink commit,
    output logic   allocatable
);

    localparam int FL_DEPTH = `NUM_PREG - `NUM_AREG;
    localparam int IDX_W    = $clog2(FL_DEPTH);

    preg_t   fl_mem [FL_DEPTH];
    fl_ptr_t head;
    fl_ptr_t cm_head;
    fl_ptr_t tail;
    fl_ptr_t head_plus1;
    fl_ptr_t tail_slot1;
    fl_ptr_t cm_head_next;
    fl_ptr_t free_count;
    logic    push0;
    logic    push1;

    function automatic fl_ptr_t ptr_add(fl_ptr_t ptr, logic inc_a, logic inc_b);
        return ptr + fl_ptr_t'(inc_a) + fl_ptr_t'(inc_b);
    endfunction

    assign push0 = commit.valid0 && commit.info0.wen;
    assign push1 = commit.valid1 && commit.info1.wen;

    assign head_plus1   = head + fl_ptr_t'(1);
    assign tail_slot1   = ptr_add(tail, push0, 1'b0);
    assign cm_head_next = ptr_add(cm_head, push0, push1); // one step per committed write.

    assign prd0 = fl_mem[head[IDX_W-1:0]];
    assign prd1 = pop0 ? fl_mem[head_plus1[IDX_W-1:0]] : prd0;

    assign free_count  = tail - head; // wrap bit keeps full and empty apart.
    assign allocatable = free_count >= fl_ptr_t'(2);

    always_ff @(posedge clk) begin
        if (reset) begin
            head    <= '0;
            cm_head <= '0;
            tail    <= fl_ptr_t'(FL_DEPTH); // queue starts full.
        end else begin
            tail    <= ptr_add(tail, push0, push1);
            cm_head <= cm_head_next;
            if (recover) begin
                head <= cm_head_next; // drop every uncommitted allocation.
            end else begin
                head <= ptr_add(head, pop0, pop1);
            end
        end
    end

    // entries past the architectural range are free at power-up
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= preg_t'(`NUM_AREG + i);
            end
        end else begin
            if (push0) begin
                fl_mem[tail[IDX_W-1:0]] <= commit.info0.prd_stale;
            end
            if (push1) begin
                fl_mem[tail_slot1[IDX_W-1:0]] <= commit.info1.prd_stale;
            end
        end
    end

endmodule

/* common/commit_if.sv */
interface commit_if import rename_pkg::*; ();

    logic         valid0;
    commit_info_t info0;
    logic         valid1;
    commit_info_t info1; // younger of the two.

    modport src (
        output valid0,
        output info0,
        output valid1,
        output info1
    );

    modport sink (
        input valid0,
        input info0,
        input valid1,
        input info1
    );

endinterface

/* common/uop_pkg.sv */
`include "rename_config.svh"

package uop_pkg;

    import rename_pkg::*;

    typedef logic [`TAG_W-1:0] tag_t;

    // one micro-op as it leaves decode and after rename fills in the physical fields
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        areg_t rs1;
        areg_t rs2;
        areg_t rd;
        logic  wen;
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        preg_t prd_stale;
    } uop_bundle_t;

endpackage

/* common/rename_pkg.sv */
`include "rename_config.svh"

package rename_pkg;

    typedef logic [$clog2(`NUM_AREG)-1:0] areg_t;
    typedef logic [$clog2(`NUM_PREG)-1:0] preg_t;
    typedef logic [$clog2(`NUM_PREG-`NUM_AREG):0] fl_ptr_t; // index plus wrap bit.

    typedef struct packed {
        areg_t rs1;
        areg_t rs2;
        areg_t rd;
        logic  wen;
    } rename_req_t;

    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        preg_t prd_stale; // old mapping of rd.
    } rename_resp_t;

    typedef struct packed {
        logic  wen;
        areg_t ard;
        preg_t prd_new;
        preg_t prd_stale; // goes back to the free list.
    } commit_info_t;

endpackage

/* common/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register count.
`define NUM_AREG 32

// physical register file size.
`define NUM_PREG 64

// pass-through tag carried with each micro-op.
`define TAG_W 8

`endif
